//--- list.f
rtl/astro_cfg_pkg.sv
rtl/astro_panel_pkg.sv
rtl/config_loader.sv
rtl/dip_bank.sv
rtl/switch_matrix.sv
rtl/astro_input_top.sv
verification/clock_gen.sv
verification/astro_input_tb.sv

//--- rtl/astro_cfg_pkg.sv
// Download stream and game configuration
package astro_cfg_pkg;

	// ==================================================
	// Download stream
	// ==================================================

	// Byte address width of the host download stream
	localparam int DL_ADDR_BITS = 25;

	// Stream index carrying the game code
	localparam logic [7:0] IDX_GAME = 8'd1;
	// Stream index carrying the DIP switch bytes
	localparam logic [7:0] IDX_DIP = 8'd254;

	// One download beat from the host
	// wr is a single-cycle strobe, no handshake
	typedef struct packed {
		logic                    wr;
		logic [7:0]              idx;
		logic [DL_ADDR_BITS-1:0] addr;
		logic [7:0]              data;
	} dl_beat_t;

	// ==================================================
	// Game selection
	// ==================================================

	// Codes as sent on IDX_GAME
	// Codes 1, 5, 6 and 7 map to GAME_NONE
	typedef enum logic [7:0] {
		GAME_NONE     = 8'd0,
		GAME_SEAWOLF2 = 8'd2,
		GAME_SPACEZAP = 8'd3,
		GAME_GORF     = 8'd4
	} game_id_t;

	// One bank of eight DIP switches
	typedef logic [7:0] dip_byte_t;

	// DIP bytes with a fixed meaning in the switch matrix
	// Byte 0 for Seawolf 2, byte 2 for Space Zap and Gorf
	// Byte 3 is read back raw on column 3
	localparam int DIP_SW2 = 0;
	localparam int DIP_GAME = 2;
	localparam int DIP_RAW = 3;

endpackage

//--- rtl/astro_input_top.sv
// Panel input path top level
module astro_input_top #(
	parameter int DIP_BYTES = 8,
	parameter int POS_BITS = 6
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  astro_cfg_pkg::dl_beat_t   dl,
	input  astro_panel_pkg::panel_t   panel,
	input  astro_panel_pkg::sticks_t  sticks,
	input  astro_panel_pkg::col_sel_t col_sel,
	input  logic                      speech_busy,
	output astro_panel_pkg::row_t     row
);
	import astro_cfg_pkg::*;

	game_id_t                       game;
	logic                           dip_we;
	logic [$clog2(DIP_BYTES)-1:0]   dip_addr;
	dip_byte_t                      dip_data;
	dip_byte_t [DIP_BYTES-1:0]      dips;

	// Host stream to game select and DIP writes
	config_loader #(
		.DIP_BYTES(DIP_BYTES)
	) config_loader_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.dl(dl),
		.game(game),
		.dip_we(dip_we),
		.dip_addr(dip_addr),
		.dip_data(dip_data)
	);

	dip_bank #(
		.DIP_BYTES(DIP_BYTES)
	) dip_bank_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.dip_we(dip_we),
		.dip_addr(dip_addr),
		.dip_data(dip_data),
		.dips(dips)
	);

	// Answers the CPU column strobes
	switch_matrix #(
		.DIP_BYTES(DIP_BYTES),
		.POS_BITS(POS_BITS)
	) switch_matrix_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.game(game),
		.dips(dips),
		.panel(panel),
		.sticks(sticks),
		.speech_busy(speech_busy),
		.col_sel(col_sel),
		.row(row)
	);

endmodule

//--- rtl/astro_panel_pkg.sv
// Control panel and switch matrix
package astro_panel_pkg;

	// ==================================================
	// Player controls
	// ==================================================

	// Digital controls of one player, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} pad_t;

	// Both players plus the shared panel buttons
	typedef struct packed {
		pad_t p1;
		pad_t p2;
		logic start1;
		logic start2;
		logic coin;
	} panel_t;

	// X axis of each analogue stick, centre at zero
	typedef struct packed {
		logic signed [7:0] p1_x;
		logic signed [7:0] p2_x;
	} sticks_t;

	// ==================================================
	// Switch matrix
	// ==================================================

	// Column strobe from the game CPU, one-hot
	typedef logic [7:0] col_sel_t;

	localparam col_sel_t COL_0 = 8'h01;
	localparam col_sel_t COL_1 = 8'h02;
	localparam col_sel_t COL_2 = 8'h04;
	localparam col_sel_t COL_3 = 8'h08;

	// Row byte returned for the strobed column
	typedef logic [7:0] row_t;

	// Nothing pulled low
	localparam row_t ROW_IDLE = 8'hff;

endpackage

//--- rtl/config_loader.sv
// Download stream configuration loader
module config_loader #(
	parameter int DIP_BYTES = 8
) (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  astro_cfg_pkg::dl_beat_t          dl,
	output astro_cfg_pkg::game_id_t          game,
	output logic                             dip_we,
	output logic [$clog2(DIP_BYTES)-1:0]     dip_addr,
	output astro_cfg_pkg::dip_byte_t         dip_data
);
	import astro_cfg_pkg::*;

	localparam int ADDR_BITS = $clog2(DIP_BYTES);

	// Last raw code seen on the game index
	logic [7:0] game_code;
	// Qualified DIP beat
	logic       dip_hit;
	logic       game_hit;

	// Only the three kept games survive
	// Codes of dropped boards fall back to none
	function automatic game_id_t decode_game(input logic [7:0] code);
		case (code)
			GAME_SEAWOLF2: return GAME_SEAWOLF2;
			GAME_SPACEZAP: return GAME_SPACEZAP;
			GAME_GORF:     return GAME_GORF;
			default:       return GAME_NONE;
		endcase
	endfunction

	assign game_hit = dl.wr && (dl.idx == IDX_GAME);
	// Address must fall inside the bank
	assign dip_hit = dl.wr && (dl.idx == IDX_DIP) && (dl.addr < DL_ADDR_BITS'(DIP_BYTES));

	// ==================================================
	// Game code, raw then decoded
	// ==================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_code <= 8'd0;
			game <= GAME_NONE;
		end else begin
			if (game_hit)
				game_code <= dl.data;
			// Decode stage, adds the second cycle
			game <= decode_game(game_code);
		end
	end

	// ==================================================
	// DIP write strobe
	// ==================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			dip_we <= 1'b0;
		else
			dip_we <= dip_hit;
	end

	// Address and byte ride along with the strobe
	always_ff @(posedge clk_sys) begin
		dip_addr <= dl.addr[ADDR_BITS-1:0];
		dip_data <= dl.data;
	end

endmodule

//--- rtl/dip_bank.sv
// DIP switch bank
module dip_bank #(
	parameter int DIP_BYTES = 8
) (
	input  logic                                     clk_sys,
	input  logic                                     reset,
	input  logic                                     dip_we,
	input  logic [$clog2(DIP_BYTES)-1:0]             dip_addr,
	input  astro_cfg_pkg::dip_byte_t                 dip_data,
	output astro_cfg_pkg::dip_byte_t [DIP_BYTES-1:0] dips
);

	// Switch settings, all open after reset
	// The loader only passes addresses inside the bank
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dips <= '0;
		end else if (dip_we) begin
			// One byte per strobe, the rest hold
			dips[dip_addr] <= dip_data;
		end
	end

endmodule

//--- rtl/switch_matrix.sv
// Operator panel switch matrix
module switch_matrix #(
	parameter int DIP_BYTES = 8,
	parameter int POS_BITS = 6
) (
	input  logic                                     clk_sys,
	input  logic                                     reset,
	input  astro_cfg_pkg::game_id_t                  game,
	input  astro_cfg_pkg::dip_byte_t [DIP_BYTES-1:0] dips,
	input  astro_panel_pkg::panel_t                  panel,
	input  astro_panel_pkg::sticks_t                 sticks,
	input  logic                                     speech_busy,
	input  astro_panel_pkg::col_sel_t                col_sel,
	output astro_panel_pkg::row_t                    row
);
	import astro_cfg_pkg::*;
	import astro_panel_pkg::*;

	// Paddle field below fire and the fixed bit
	localparam int FIELD_BITS = $bits(row_t) - 2;
	// Moves the signed stick centre to mid scale
	localparam logic [POS_BITS-1:0] SIGN_FLIP = {1'b1, {(POS_BITS-1){1'b0}}};

	logic [POS_BITS-1:0]   gray_p1;
	logic [POS_BITS-1:0]   gray_p2;
	logic [FIELD_BITS-1:0] field_p1;
	logic [FIELD_BITS-1:0] field_p2;

	// Row bytes for columns 0 to 3, per game
	row_t [3:0] sw2_rows;
	row_t [3:0] sz_rows;
	row_t [3:0] gf_rows;
	row_t [3:0] game_rows;

	// Coarse stick position, then binary to Gray
	function automatic logic [POS_BITS-1:0] paddle_gray(input logic signed [7:0] x);
		logic [POS_BITS-1:0] pos;
		pos = x[7 -: POS_BITS] ^ SIGN_FLIP;
		return pos ^ (pos >> 1);
	endfunction

	// Low five bits of a pad column, buttons pull low
	function automatic logic [4:0] pad_low(input pad_t pad);
		return {~pad.fire, ~pad.right, ~pad.left, ~pad.down, ~pad.up};
	endfunction

	// Paddle registers, one cycle from stick to row
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			gray_p1 <= '0;
			gray_p2 <= '0;
		end else begin
			gray_p1 <= paddle_gray(sticks.p1_x);
			gray_p2 <= paddle_gray(sticks.p2_x);
		end
	end

	assign field_p1 = FIELD_BITS'(gray_p1);
	assign field_p2 = FIELD_BITS'(gray_p2);

	// ==================================================
	// Seawolf 2
	// ==================================================
	// Fire and starts are active high on this board
	assign sw2_rows[0] = {panel.p2.fire, 1'b1, field_p2};
	assign sw2_rows[1] = {panel.p1.fire, dips[DIP_SW2][0], field_p1};
	assign sw2_rows[2] = {4'hf, dips[DIP_SW2][1], panel.start2, panel.start1, panel.coin};
	assign sw2_rows[3] = dips[DIP_RAW];

	// ==================================================
	// Space Zap
	// ==================================================
	assign sz_rows[0] = {2'b11, ~panel.start2, ~panel.start1, dips[DIP_GAME][1],
		1'b1, ~panel.coin, 1'b1};
	assign sz_rows[1] = {3'b111, pad_low(panel.p2)};
	assign sz_rows[2] = {2'b11, dips[DIP_GAME][0], pad_low(panel.p1)};
	assign sz_rows[3] = dips[DIP_RAW];

	// ==================================================
	// Gorf
	// ==================================================
	assign gf_rows[0] = {dips[DIP_GAME][2], dips[DIP_GAME][0], ~panel.start2, ~panel.start1,
		1'b1, dips[DIP_GAME][1], ~panel.coin, 1'b1};
	assign gf_rows[1] = {3'b001, pad_low(panel.p2)};
	// Top bit reports the speech chip still talking
	assign gf_rows[2] = {speech_busy, 2'b01, pad_low(panel.p1)};
	assign gf_rows[3] = dips[DIP_RAW];

	// ==================================================
	// Column select
	// ==================================================
	// No game leaves every column idle, column 3 included
	always_comb begin
		case (game)
			GAME_SEAWOLF2: game_rows = sw2_rows;
			GAME_SPACEZAP: game_rows = sz_rows;
			GAME_GORF:     game_rows = gf_rows;
			default:       game_rows = {4{ROW_IDLE}};
		endcase
	end

	always_comb begin
		case (col_sel)
			COL_0:   row = game_rows[0];
			COL_1:   row = game_rows[1];
			COL_2:   row = game_rows[2];
			COL_3:   row = game_rows[3];
			// Zero, multi-hot or upper columns
			default: row = ROW_IDLE;
		endcase
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the panel input testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module astro_input_tb -o astro_input_sim \
	&& ./obj_dir/astro_input_sim | tee /dev/stderr | grep -qx "TEST OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verification/astro_input_tb.sv
// Panel input path testbench
module astro_input_tb;
	import astro_cfg_pkg::*;
	import astro_panel_pkg::*;

	localparam int DIP_BYTES = 8;
	localparam int POS_BITS = 6;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int PADDLE_CASES = 16;
	// Reset and then each test in run order
	localparam int TEST_CYCLES = RESET_CYCLES + 9 + 3 * 37 + 2 * 59
		+ (8 + 5 * PADDLE_CASES) + 24;
	localparam int MARGIN = 64 * CLK_PERIOD;

	logic      clk_sys;
	logic      reset;
	dl_beat_t  dl;
	panel_t    panel;
	sticks_t   sticks;
	col_sel_t  col_sel;
	logic      speech_busy;
	row_t      row;

	// State the DUT should hold after the loads so far
	logic [7:0] model_code;
	dip_byte_t  model_dips [0:DIP_BYTES-1];

	int     errors = 0;
	int     checks = 0;
	integer seed = 32'ha062_b9a3;

	clock_gen #(
		.HALF_PERIOD(CLK_PERIOD / 2),
		.RESET_CYCLES(RESET_CYCLES)
	) clock_gen_i (
		.clk_sys(clk_sys),
		.reset(reset)
	);

	astro_input_top #(
		.DIP_BYTES(DIP_BYTES),
		.POS_BITS(POS_BITS)
	) astro_input_top_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.dl(dl),
		.panel(panel),
		.sticks(sticks),
		.col_sel(col_sel),
		.speech_busy(speech_busy),
		.row(row)
	);

	// ==================================================
	// Reference model of the row tables
	// ==================================================

	// Top stick bits with the sign flipped, then Gray
	function automatic logic [POS_BITS-1:0] gray_pos(input logic signed [7:0] x);
		logic [POS_BITS-1:0] bin;
		logic [POS_BITS-1:0] g;
		int i;
		bin = x[7 -: POS_BITS];
		bin[POS_BITS-1] = ~bin[POS_BITS-1];
		g[POS_BITS-1] = bin[POS_BITS-1];
		for (i = 0; i < POS_BITS - 1; i++)
			g[i] = bin[i + 1] ^ bin[i];
		return g;
	endfunction

	// Pad bits from fire down to up, all pulling low
	function automatic logic [4:0] inverted_pad(input pad_t p);
		return {~p.fire, ~p.right, ~p.left, ~p.down, ~p.up};
	endfunction

	function automatic row_t expected_row(input col_sel_t col, input sticks_t st);
		int c;
		row_t r;
		dip_byte_t d0;
		dip_byte_t d2;
		case (col)
			8'h01:   c = 0;
			8'h02:   c = 1;
			8'h04:   c = 2;
			8'h08:   c = 3;
			default: c = -1;
		endcase
		d0 = model_dips[0];
		d2 = model_dips[2];
		r = ROW_IDLE;
		// Unknown or dropped codes keep every column idle
		case (model_code)
			GAME_SEAWOLF2: case (c)
				0: r = {panel.p2.fire, 1'b1, gray_pos(st.p2_x)};
				1: r = {panel.p1.fire, d0[0], gray_pos(st.p1_x)};
				2: r = {4'hf, d0[1], panel.start2, panel.start1, panel.coin};
				3: r = model_dips[3];
				default: r = ROW_IDLE;
			endcase
			GAME_SPACEZAP: case (c)
				0: r = {2'b11, ~panel.start2, ~panel.start1, d2[1], 1'b1, ~panel.coin, 1'b1};
				1: r = {3'b111, inverted_pad(panel.p2)};
				2: r = {2'b11, d2[0], inverted_pad(panel.p1)};
				3: r = model_dips[3];
				default: r = ROW_IDLE;
			endcase
			GAME_GORF: case (c)
				0: r = {d2[2], d2[0], ~panel.start2, ~panel.start1, 1'b1, d2[1], ~panel.coin, 1'b1};
				1: r = {3'b001, inverted_pad(panel.p2)};
				2: r = {speech_busy, 2'b01, inverted_pad(panel.p1)};
				3: r = model_dips[3];
				default: r = ROW_IDLE;
			endcase
			default: r = ROW_IDLE;
		endcase
		return r;
	endfunction

	// ==================================================
	// Drive and compare
	// ==================================================

	// Inputs change one unit after the rising edge
	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_row(input string name, input row_t exp, input row_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Row is combinational, sampled one unit after the strobe
	task automatic probe_col(input col_sel_t col);
		next_cycle;
		col_sel = col;
		#1;
	endtask

	task automatic check_col(input string name, input col_sel_t col);
		probe_col(col);
		check_row($sformatf("%s col %h", name, col), expected_row(col, sticks), row);
	endtask

	task automatic check_columns(input string name);
		int c;
		for (c = 0; c < 4; c++)
			check_col(name, col_sel_t'(8'h01 << c));
	endtask

	// Single-cycle write strobe without a handshake
	task automatic send_beat(input logic [7:0] idx, input int addr, input dip_byte_t data);
		next_cycle;
		dl.wr = 1'b1;
		dl.idx = idx;
		dl.addr = DL_ADDR_BITS'(addr);
		dl.data = data;
		next_cycle;
		dl = '0;
	endtask

	task automatic load_game(input logic [7:0] code);
		send_beat(IDX_GAME, 0, code);
		model_code = code;
		repeat (2) next_cycle;
	endtask

	// Only the DIP index inside the bank reaches the switches
	task automatic load_dip(input logic [7:0] idx, input int addr, input dip_byte_t data);
		send_beat(idx, addr, data);
		if (idx == IDX_DIP && addr < DIP_BYTES)
			model_dips[addr] = data;
		repeat (2) next_cycle;
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic idle_after_reset;
		int i;
		probe_col(8'h00);
		check_row("idle after reset col 00", ROW_IDLE, row);
		for (i = 0; i < 8; i++) begin
			probe_col(col_sel_t'(8'h01 << i));
			check_row($sformatf("idle after reset col %h", col_sel), ROW_IDLE, row);
		end
	endtask

	task automatic dip_loading(input game_id_t g);
		dip_byte_t v0;
		dip_byte_t v2;
		dip_byte_t v3;
		v0 = 8'($random(seed));
		v2 = 8'($random(seed));
		v3 = 8'($random(seed));
		load_game(g);
		load_dip(IDX_DIP, 0, v0);
		load_dip(IDX_DIP, 2, v2);
		load_dip(IDX_DIP, 3, v3);
		check_columns($sformatf("dip load game %0d", g));
		// Wrong index, then addresses past the bank
		load_dip(8'd253, 3, ~v3);
		load_dip(IDX_DIP, DIP_BYTES, ~v0);
		load_dip(IDX_DIP, DIP_BYTES + 3, ~v3);
		check_columns($sformatf("dip stray game %0d", g));
		check_col($sformatf("dip upper col game %0d", g), 8'h10);
	endtask

	task automatic panel_walk(input game_id_t g);
		int i;
		load_game(g);
		for (i = 0; i < $bits(panel_t); i++) begin
			next_cycle;
			panel = 13'(1) << i;
			check_col($sformatf("walk game %0d bit %0d", g, i), COL_0);
			check_col($sformatf("walk game %0d bit %0d", g, i), COL_1);
			check_col($sformatf("walk game %0d bit %0d", g, i), COL_2);
		end
		next_cycle;
		panel = '0;
		speech_busy = 1'b1;
		check_col($sformatf("speech busy game %0d", g), COL_2);
		next_cycle;
		speech_busy = 1'b0;
	endtask

	// Paddle registers lag the stick by one cycle
	task automatic paddle_check;
		int i;
		sticks_t held;
		col_sel_t col;
		load_game(GAME_SEAWOLF2);
		load_dip(IDX_DIP, 0, 8'($random(seed)));
		for (i = 0; i < PADDLE_CASES; i++) begin
			next_cycle;
			held = sticks;
			col = (i % 2 == 0) ? COL_0 : COL_1;
			// Both extremes first, then centre, then random
			if (i == 0) begin
				sticks = {8'h80, 8'h7f};
			end else if (i == 1) begin
				sticks = '0;
			end else begin
				sticks.p1_x = 8'($random(seed));
				sticks.p2_x = 8'($random(seed));
			end
			panel = 13'($random(seed));
			col_sel = col;
			#1;
			// Same cycle as the stick change, old position still shown
			check_row($sformatf("paddle hold case %0d col %h", i, col),
				expected_row(col, held), row);
			check_columns($sformatf("paddle case %0d", i));
		end
	endtask

	task automatic dropped_game;
		load_game(8'd5);
		check_columns("dropped code 5");
		load_game(8'd7);
		check_columns("dropped code 7");
		load_game(GAME_SPACEZAP);
		check_columns("restored space zap");
	endtask

	// ==================================================
	// Sequence and watchdog
	// ==================================================
	initial begin
		int i;
		dl = '0;
		panel = '0;
		sticks = '0;
		col_sel = '0;
		speech_busy = 1'b0;
		model_code = 8'd0;
		for (i = 0; i < DIP_BYTES; i++)
			model_dips[i] = '0;
		@(negedge reset);
		idle_after_reset();
		dip_loading(GAME_SEAWOLF2);
		dip_loading(GAME_SPACEZAP);
		dip_loading(GAME_GORF);
		panel_walk(GAME_SPACEZAP);
		panel_walk(GAME_GORF);
		paddle_check();
		dropped_game();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(TEST_CYCLES * CLK_PERIOD + MARGIN);
		$display("Run timed out, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verification/clock_gen.sv
// Testbench clock and reset
module clock_gen #(
	parameter int HALF_PERIOD = 2,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_sys,
	output logic reset
);

	// Free running clock, period of two half periods
	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	// Reset held for a fixed number of rising edges
	// Released off the edge so the async clear never races the clock
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	end

endmodule
